// File: sources.f
hdl/seed_pkg.sv
hdl/i2c_byte_engine.sv
hdl/eeprom_register_helper.sv
hdl/seed_persistence_manager.sv
hdl/seed_eeprom_top.sv
verification/eeprom_model.sv
verification/tb_seed_eeprom.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_seed_eeprom -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/Vtb_seed_eeprom)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verification/tb_seed_eeprom.sv
module tb_seed_eeprom;
	import seed_pkg::*;

	typedef struct packed {
		logic        model_en;     // Device answers
		logic [15:0] grant_delay;  // Cycles from bus_req to bus_grant
		logic        expect_ok;
	} row_t;

	localparam int NUM_ROWS = 4;
	localparam int WAIT_MAX = 20000;  // Cycles per wait

	logic  clk;
	logic  arst_n;
	logic  load_en;
	logic  bus_grant;
	logic  model_en;
	logic  bus_req;
	logic  bus_done;
	logic  scl_oe;
	logic  sda_oe;
	logic  model_sda_oe;
	logic  seed_valid;
	logic  seed_error;
	seed_t seed;
	wire   scl;
	wire   sda;

	row_t        rows [NUM_ROWS];
	logic [31:0] lfsr;
	logic        timed_out;
	int          value_errors;
	int          other_errors;
	int          monitor_errors = 0;
	int          done_count     = 0;  // bus_done pulses seen
	logic        req_q          = 1'b0;

	// Pull-ups with wired-AND
	assign scl = !scl_oe;                   // Master is the only SCL driver
	assign sda = !(sda_oe || model_sda_oe);

	seed_eeprom_top #(
		.addr_pins(3'h5)
	) i_seed_eeprom_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.load_en   (load_en),
		.bus_grant (bus_grant),
		.sda_in    (sda),
		.bus_req   (bus_req),
		.bus_done  (bus_done),
		.scl_oe    (scl_oe),
		.sda_oe    (sda_oe),
		.seed_valid(seed_valid),
		.seed      (seed),
		.seed_error(seed_error)
	);

	eeprom_model #(
		.addr_pins(3'h5)
	) i_eeprom_model (
		.enable(model_en),
		.scl   (scl),
		.sda   (sda),
		.sda_oe(model_sda_oe)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers and compare tasks

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);  // Galois form with taps 32 30 26 25
	endfunction

	task automatic next_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);  // One step per bit
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_seed(input seed_t got, input seed_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED time=%0t signal=seed got=%h expected=%h", $time, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
		end
	endtask

	// Bus rules that hold on every cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (bus_done)
				done_count++;
			if (req_q && !bus_req && !bus_done) begin
				monitor_errors++;
				$display("bus_req dropped without a bus_done pulse at time %0t", $time);
			end
			if (!bus_grant && (scl_oe || sda_oe)) begin
				monitor_errors++;
				$display("SCL or SDA pulled low while the bus was not granted at time %0t", $time);
			end
		end
		req_q <= bus_req;
	end

	////////////////////////////////////////////////////////////
	// One table row from load to result

	task automatic run_row(input int idx, input row_t row);
		seed_t expected;
		byte_t b;
		byte_t addr;
		logic  was_valid;
		logic  seen_error;
		int    done_before;
		int    n;

		for (int i = 0; i < SEED_BYTES; i++) begin
			next_byte(b);
			addr = SEED_WORD_ADDR + byte_t'(i);
			i_eeprom_model.mem[addr] = b;
			expected[(SEED_BYTES - 1 - i) * 8 +: 8] = b;  // A0h ends up on top
		end

		was_valid   = seed_valid;
		done_before = done_count;
		model_en    = row.model_en;
		load_en     = 1'b1;
		@(negedge clk);
		load_en = 1'b0;
		if (was_valid)
			check_bit("seed_valid", seed_valid, 1'b0);  // Reload drops the old seed

		n = 0;
		while (!bus_req && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (!bus_req) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Row %0d timed out waiting for bus_req", idx);
			return;
		end

		// Arbiter holds off while the monitor watches the pins
		repeat (row.grant_delay) begin
			@(negedge clk);
			check_bit("bus_req", bus_req, 1'b1);
		end
		bus_grant = 1'b1;

		n = 0;
		while (!seed_valid && !seed_error && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (!seed_valid && !seed_error) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Row %0d timed out waiting for seed_valid or seed_error", idx);
			return;
		end
		seen_error = seed_error;
		bus_grant  = 1'b0;

		check_bit("seed_error", seen_error, !row.expect_ok);
		check_bit("seed_valid", seed_valid, row.expect_ok);
		if (row.expect_ok)
			check_seed(seed, expected);

		repeat (20) @(negedge clk);
		check_bit("seed_valid", seed_valid, row.expect_ok);  // Level holds
		check_bit("seed_error", seed_error, 1'b0);           // Single pulse
		check_bit("bus_req", bus_req, 1'b0);
		if (done_count != done_before + 1) begin
			other_errors++;
			$display("Row %0d saw %0d bus_done pulses instead of one", idx,
				done_count - done_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		arst_n       = 1'b0;
		load_en      = 1'b0;
		bus_grant    = 1'b0;
		model_en     = 1'b0;
		lfsr         = 32'h7dd048f5;
		timed_out    = 1'b0;
		value_errors = 0;
		other_errors = 0;

		rows[0] = '{model_en: 1'b1, grant_delay: 16'd0,   expect_ok: 1'b1};
		rows[1] = '{model_en: 1'b1, grant_delay: 16'd300, expect_ok: 1'b1};  // Late grant
		rows[2] = '{model_en: 1'b0, grant_delay: 16'd0,   expect_ok: 1'b0};  // No device
		rows[3] = '{model_en: 1'b1, grant_delay: 16'd0,   expect_ok: 1'b1};  // Reload

		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("bus_req", bus_req, 1'b0);
		check_bit("bus_done", bus_done, 1'b0);
		check_bit("seed_valid", seed_valid, 1'b0);
		check_bit("seed_error", seed_error, 1'b0);
		check_bit("scl_oe", scl_oe, 1'b0);
		check_bit("sda_oe", sda_oe, 1'b0);
		check_seed(seed, '0);

		for (int r = 0; r < NUM_ROWS && !timed_out; r++)
			run_row(r, rows[r]);

		repeat (5) @(negedge clk);
		$display("Summary: %0d value errors, %0d other errors", value_errors,
			other_errors + monitor_errors);
		if (value_errors == 0 && other_errors + monitor_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verification/eeprom_model.sv
module eeprom_model #(
	parameter seed_pkg::addr_pins_t addr_pins = 3'h0  // A2..A0 straps
) (
	input  logic enable,  // Low makes the device ignore every address
	input  wire  scl,
	input  wire  sda,
	output logic sda_oe   // High pulls SDA low
);
	import seed_pkg::*;

	byte_t      mem [256];          // Filled by the testbench
	byte_t      shift      = '0;
	byte_t      ptr        = '0;    // Current word address
	logic [3:0] bit_cnt    = '0;
	logic       ack_phase  = 1'b0;  // Ninth clock of a byte
	logic       got_dev    = 1'b0;  // Device byte taken since start
	logic       active     = 1'b0;  // Addressed by the master
	logic       reading    = 1'b0;
	logic       sending    = 1'b0;
	logic       master_ack = 1'b0;
	logic       pull       = 1'b0;
	logic       scl_q      = 1'b1;
	logic       sda_q      = 1'b1;

	assign sda_oe = pull;

	////////////////////////////////////////////////////////////
	// Bus watcher, runs on every edge of either line

	always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
		if (scl && scl_q && sda_q && !sda) begin          // Start or repeated start
			bit_cnt   = '0;
			ack_phase = 1'b0;
			got_dev   = 1'b0;
			active    = 1'b0;
			sending   = 1'b0;
			pull      = 1'b0;
		end else if (scl && scl_q && !sda_q && sda) begin // Stop
			active  = 1'b0;
			sending = 1'b0;
			pull    = 1'b0;
		end else if (scl && !scl_q) begin                 // Rising SCL
			if (ack_phase)
				master_ack = !sda;                        // Low is ACK from master
			else begin
				if (!sending)
					shift = {shift[6:0], sda};
				bit_cnt = bit_cnt + 4'd1;
			end
		end else if (!scl && scl_q) begin                 // Falling SCL
			if (ack_phase) begin
				ack_phase = 1'b0;
				bit_cnt   = '0;
				pull      = 1'b0;
				// Next read byte, unless the master said NACK
				if (active && reading && (!sending || master_ack)) begin
					shift   = mem[ptr];
					ptr     = ptr + 8'd1;
					sending = 1'b1;
					pull    = !shift[7];
				end else
					sending = 1'b0;
			end else if (bit_cnt == 4'd8) begin
				ack_phase = 1'b1;
				pull      = 1'b0;                         // Release after a sent byte
				if (!sending) begin
					if (!got_dev) begin
						got_dev = 1'b1;
						active  = enable && (shift[7:1] == {EEPROM_DEV_PREFIX, addr_pins});
						reading = shift[0];
						pull    = active;                 // ACK own address only
					end else if (active) begin
						ptr  = shift;                     // Word address
						pull = 1'b1;
					end
				end
			end else if (sending && bit_cnt != 4'd0) begin
				shift = {shift[6:0], 1'b0};
				pull  = !shift[7];                        // MSB first
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

// File: hdl/seed_eeprom_top.sv
module seed_eeprom_top #(
	parameter seed_pkg::addr_pins_t addr_pins = 3'h0  // EEPROM strap pins
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            load_en,
	input  logic            bus_grant,
	input  logic            sda_in,
	output logic            bus_req,
	output logic            bus_done,
	output logic            scl_oe,
	output logic            sda_oe,
	output logic            seed_valid,
	output seed_pkg::seed_t seed,
	output logic            seed_error
);
	import seed_pkg::*;

	////////////////////////////////////////////////////////////
	// Manager to helper

	logic  open;
	logic  ready;
	logic  select;
	logic  rdata_valid;
	byte_t rdata;
	logic  burst_done;
	logic  err;

	// Helper to engine
	logic     cmd_valid;
	i2c_cmd_t cmd;
	logic     rsp_valid;
	i2c_rsp_t rsp;

	seed_persistence_manager i_manager (
		.clk        (clk),
		.arst_n     (arst_n),
		.load_en    (load_en),
		.ready      (ready),
		.rdata_valid(rdata_valid),
		.rdata      (rdata),
		.burst_done (burst_done),
		.err        (err),
		.open       (open),
		.select     (select),
		.seed_valid (seed_valid),
		.seed       (seed),
		.seed_error (seed_error)
	);

	eeprom_register_helper #(
		.addr_pins(addr_pins)
	) i_helper (
		.clk        (clk),
		.arst_n     (arst_n),
		.open       (open),
		.select     (select),
		.bus_grant  (bus_grant),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.ready      (ready),
		.rdata_valid(rdata_valid),
		.rdata      (rdata),
		.burst_done (burst_done),
		.err        (err),
		.bus_req    (bus_req),
		.bus_done   (bus_done),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd)
	);

	i2c_byte_engine i_engine (
		.clk      (clk),
		.arst_n   (arst_n),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.sda_in   (sda_in),   // Wired-AND line from the pad
		.rsp_valid(rsp_valid),
		.rsp      (rsp),
		.scl_oe   (scl_oe),
		.sda_oe   (sda_oe)
	);

endmodule

// File: hdl/seed_persistence_manager.sv
module seed_persistence_manager (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            load_en,
	input  logic            ready,
	input  logic            rdata_valid,
	input  seed_pkg::byte_t rdata,
	input  logic            burst_done,
	input  logic            err,
	output logic            open,
	output logic            select,
	output logic            seed_valid,
	output seed_pkg::seed_t seed,
	output logic            seed_error
);
	import seed_pkg::*;

	typedef enum logic [1:0] {
		BOOT_OPEN,   // Waiting on first load
		WAIT_READY,  // Bus requested
		READ,        // Burst running
		IDLE         // Seed held
	} mgr_state_t;

	mgr_state_t state;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= BOOT_OPEN;
			open       <= 1'b0;
			select     <= 1'b0;
			seed_valid <= 1'b0;
			seed       <= '0;
			seed_error <= 1'b0;
		end else begin
			open       <= 1'b0;
			select     <= 1'b0;
			seed_error <= 1'b0;
			case (state)
				BOOT_OPEN: if (load_en) begin
					open  <= 1'b1;
					state <= WAIT_READY;
				end

				WAIT_READY: if (ready) begin
					select <= 1'b1;   // Burst start
					state  <= READ;
				end

				READ: begin
					// First byte ends up on top
					if (rdata_valid)
						seed <= {seed[$bits(seed_t)-$bits(byte_t)-1:0], rdata};
					if (burst_done) begin
						seed_valid <= 1'b1;
						state      <= IDLE;
					end else if (err) begin
						seed_error <= 1'b1;   // Seed never claimed valid
						state      <= BOOT_OPEN;
					end
				end

				default: if (load_en) begin   // Reload request
					seed_valid <= 1'b0;
					open       <= 1'b1;
					state      <= WAIT_READY;
				end
			endcase
		end
	end

endmodule

// File: hdl/eeprom_register_helper.sv
module eeprom_register_helper #(
	parameter seed_pkg::addr_pins_t addr_pins = 3'h0
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               open,
	input  logic               select,
	input  logic               bus_grant,
	input  logic               rsp_valid,
	input  seed_pkg::i2c_rsp_t rsp,
	output logic               ready,
	output logic               rdata_valid,
	output seed_pkg::byte_t    rdata,
	output logic               burst_done,
	output logic               err,
	output logic               bus_req,
	output logic               bus_done,
	output logic               cmd_valid,
	output seed_pkg::i2c_cmd_t cmd
);
	import seed_pkg::*;

	typedef logic [$clog2(SEED_BYTES + 1)-1:0] count_t;

	typedef enum logic [3:0] {
		H_IDLE,
		H_GRANT,   // bus_req up, waiting on arbiter
		H_READY,   // Bus owned, waiting on select
		H_START,
		H_DEV_W,
		H_WORD,
		H_RSTART,
		H_DEV_R,
		H_READ,
		H_STOP
	} helper_state_t;

	helper_state_t state;
	count_t        remaining;  // Bytes still to read
	logic          abort;      // NACK seen, stop ends with err
	logic          last_read;

	assign ready       = (state == H_READY);
	assign last_read   = (remaining == count_t'(1));
	assign rdata_valid = rsp_valid && (state == H_READ);
	assign rdata       = rsp.rdata;

	////////////////////////////////////////////////////////////
	// Command of the step in flight

	always_comb begin
		cmd = '{op: OP_START, wdata: 8'h00, nack_last: 1'b0};
		case (state)
			H_DEV_W: begin
				cmd.op    = OP_WRITE;
				cmd.wdata = {EEPROM_DEV_PREFIX, addr_pins, 1'b0}; // Write direction
			end
			H_WORD: begin
				cmd.op    = OP_WRITE;
				cmd.wdata = SEED_WORD_ADDR;
			end
			H_DEV_R: begin
				cmd.op    = OP_WRITE;
				cmd.wdata = {EEPROM_DEV_PREFIX, addr_pins, 1'b1}; // Read direction
			end
			H_READ: begin
				cmd.op        = OP_READ;
				cmd.nack_last = last_read;  // NACK ends the burst
			end
			H_STOP:  cmd.op = OP_STOP;
			default: ;                      // START for H_START and H_RSTART
		endcase
	end

	////////////////////////////////////////////////////////////
	// Random read sequencer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= H_IDLE;
			remaining  <= '0;
			abort      <= 1'b0;
			bus_req    <= 1'b0;
			bus_done   <= 1'b0;
			burst_done <= 1'b0;
			err        <= 1'b0;
			cmd_valid  <= 1'b0;
		end else begin
			cmd_valid  <= 1'b0;
			bus_done   <= 1'b0;
			burst_done <= 1'b0;
			err        <= 1'b0;
			case (state)
				H_IDLE: if (open) begin
					bus_req <= 1'b1;
					state   <= H_GRANT;
				end
				H_GRANT: if (bus_grant)
					state <= H_READY;
				H_READY: if (select) begin
					remaining <= count_t'(SEED_BYTES);
					abort     <= 1'b0;
					cmd_valid <= 1'b1;
					state     <= H_START;
				end
				H_START: if (rsp_valid) begin
					cmd_valid <= 1'b1;
					state     <= H_DEV_W;
				end
				H_DEV_W: if (rsp_valid) begin
					cmd_valid <= 1'b1;
					abort     <= !rsp.ack_seen;
					state     <= rsp.ack_seen ? H_WORD : H_STOP; // Absent device
				end
				H_WORD: if (rsp_valid) begin
					cmd_valid <= 1'b1;
					abort     <= !rsp.ack_seen;
					state     <= rsp.ack_seen ? H_RSTART : H_STOP;
				end
				H_RSTART: if (rsp_valid) begin
					cmd_valid <= 1'b1;
					state     <= H_DEV_R;
				end
				H_DEV_R: if (rsp_valid) begin
					cmd_valid <= 1'b1;
					abort     <= !rsp.ack_seen;
					state     <= rsp.ack_seen ? H_READ : H_STOP;
				end
				H_READ: if (rsp_valid) begin
					remaining <= remaining - 1'b1;
					cmd_valid <= 1'b1;
					if (last_read)
						state <= H_STOP;
				end
				H_STOP: if (rsp_valid) begin
					bus_req  <= 1'b0;   // Bus handed back
					bus_done <= 1'b1;
					if (abort)
						err <= 1'b1;
					else
						burst_done <= 1'b1;
					state <= H_IDLE;
				end
				default: state <= H_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/i2c_byte_engine.sv
module i2c_byte_engine (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               cmd_valid,
	input  seed_pkg::i2c_cmd_t cmd,
	input  logic               sda_in,
	output logic               rsp_valid,
	output seed_pkg::i2c_rsp_t rsp,
	output logic               scl_oe,   // High pulls SCL low
	output logic               sda_oe    // High pulls SDA low
);
	import seed_pkg::*;

	typedef logic [$clog2(I2C_QUARTER_CYCLES)-1:0] presc_t;

	typedef enum logic [1:0] {
		E_IDLE,
		E_START,
		E_STOP,
		E_BYTE
	} eng_state_t;

	eng_state_t state;
	presc_t     presc;      // Cycle within the quarter
	logic [1:0] qtr;        // Quarter within the bit
	logic [3:0] bit_idx;    // 0..7 data, 8 is the ACK slot
	byte_t      shift;      // Out on writes, in on reads
	logic       is_read;
	logic       nack_last;
	logic       ack_seen;
	logic       busy;
	logic       qtr_first;
	logic       qtr_last;
	logic       sample_en;
	logic       op_end;
	logic       drive_low;  // SDA level for the current bit

	assign busy      = (state != E_IDLE);
	assign qtr_first = busy && (presc == '0);
	assign qtr_last  = busy && (presc == presc_t'(I2C_QUARTER_CYCLES - 1));
	assign sample_en = (state == E_BYTE) && qtr_last && (qtr == 2'd2); // End of SCL high
	assign op_end    = qtr_last && (qtr == 2'd3) && ((state != E_BYTE) || (bit_idx == 4'd8));

	assign rsp.rdata    = shift;
	assign rsp.ack_seen = ack_seen;

	always_comb begin
		if (bit_idx == 4'd8)
			drive_low = is_read && !nack_last; // Master ACK on reads, release on writes
		else
			drive_low = !is_read && !shift[7]; // MSB first
	end

	////////////////////////////////////////////////////////////
	// Prescaler and bit sequencer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= E_IDLE;
			presc     <= '0;
			qtr       <= '0;
			bit_idx   <= '0;
			scl_oe    <= 1'b0;
			sda_oe    <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (!busy) begin
				if (cmd_valid) begin
					presc   <= '0;
					qtr     <= '0;
					bit_idx <= '0;
					case (cmd.op)
						OP_START: state <= E_START;
						OP_STOP:  state <= E_STOP;
						default:  state <= E_BYTE;
					endcase
				end
			end else begin
				presc <= qtr_last ? '0 : presc + 1'b1;

				// Pins move at the start of a quarter
				if (qtr_first) begin
					case (state)
						E_START: begin
							case (qtr)
								2'd0:    sda_oe <= 1'b0; // Release SDA first, repeated start
								2'd1:    scl_oe <= 1'b0;
								2'd2:    sda_oe <= 1'b1; // SDA falls while SCL high
								default: scl_oe <= 1'b1;
							endcase
						end
						E_STOP: begin
							case (qtr)
								2'd0:    sda_oe <= 1'b1; // SCL still low here
								2'd1:    scl_oe <= 1'b0;
								2'd2:    sda_oe <= 1'b0; // SDA rises while SCL high
								default: ;               // Bus idle
							endcase
						end
						default: begin
							case (qtr)
								2'd0:    sda_oe <= drive_low;
								2'd1:    scl_oe <= 1'b0;
								2'd3:    scl_oe <= 1'b1;
								default: ;               // Slave samples
							endcase
						end
					endcase
				end

				if (qtr_last) begin
					qtr <= qtr + 1'b1;
					if (qtr == 2'd3)
						bit_idx <= bit_idx + 1'b1;
				end

				if (op_end) begin
					state     <= E_IDLE;
					rsp_valid <= 1'b1;
				end
			end
		end
	end

	// Byte payload and ACK capture
	always_ff @(posedge clk) begin
		if (!busy && cmd_valid) begin
			shift     <= cmd.wdata;
			is_read   <= (cmd.op == OP_READ);
			nack_last <= cmd.nack_last;
		end else if (sample_en) begin
			if (bit_idx == 4'd8)
				ack_seen <= !sda_in;             // Low means ACK
			else
				shift <= {shift[6:0], sda_in};   // Readback on writes
		end
	end

endmodule

// File: hdl/seed_pkg.sv
package seed_pkg;

	////////////////////////////////////////////////////////////
	// Data widths

	typedef logic [7:0]   byte_t;       // One EEPROM data byte
	typedef logic [127:0] seed_t;       // Assembled RNG seed
	typedef logic [2:0]   addr_pins_t;  // A2..A0 straps of the EEPROM

	////////////////////////////////////////////////////////////
	// EEPROM layout

	localparam int         SEED_BYTES        = 16;      // Burst length
	localparam byte_t      SEED_WORD_ADDR    = 8'hA0;   // Seed lives at A0h..AFh
	localparam logic [3:0] EEPROM_DEV_PREFIX = 4'b1010; // 24C family code

	// Clock cycles per quarter SCL period
	localparam int I2C_QUARTER_CYCLES = 4;

	////////////////////////////////////////////////////////////
	// Helper to byte engine

	typedef enum logic [1:0] {
		OP_START,  // Start or repeated start
		OP_STOP,
		OP_WRITE,  // Byte out, ACK in
		OP_READ    // Byte in, ACK/NACK out
	} i2c_op_t;

	typedef struct packed {
		i2c_op_t op;
		byte_t   wdata;
		logic    nack_last;  // NACK instead of ACK after a read
	} i2c_cmd_t;

	typedef struct packed {
		byte_t rdata;
		logic  ack_seen;     // Slave pulled SDA in the ACK slot
	} i2c_rsp_t;

endpackage
